//--- decodeStage.sv
`timescale 1ns/1ns
`include "gpu_defines.svh"

module decodeStage (
	input logic clk,
	input logic rstN,
	input pipePkg::fetchSlotS fetchSlot0,
	input pipePkg::fetchSlotS fetchSlot1,
	output pipePkg::ibEntryS ibWrite0,
	output pipePkg::ibEntryS ibWrite1,
	output logic [`NUM_WARPS-1:0] ibMask0,
	output logic [`NUM_WARPS-1:0] ibMask1,
	output pipePkg::simtCtrlS simtCtrl0,
	output pipePkg::simtCtrlS simtCtrl1,
	output pipePkg::pcRedirectS redirect0,
	output pipePkg::pcRedirectS redirect1
);

	pipePkg::fetchSlotS slot [2];
	pipePkg::ibEntryS entryQ [2];
	pipePkg::simtCtrlS simtQ [2];
	pipePkg::pcRedirectS redirOut [2];
	logic [`NUM_WARPS-1:0] redirMaskQ [2];
	logic [`XLEN-1:0] targetQ [2];

	assign slot[0] = fetchSlot0;
	assign slot[1] = fetchSlot1;

	for (genvar s = 0; s < 2; s++) begin : gSlot
		pipePkg::ibEntryS entryD;
		logic dotS;
		logic call;
		logic ret;
		logic jmp;
		logic [`XLEN-1:0] retAddr;
		logic [`XLEN-1:0] target;

		instrDecoder uDecoder (
			.instr(slot[s].instr),
			.pcPlus4(slot[s].pcPlus4),
			.entry(entryD),
			.dotS(dotS),
			.call(call),
			.ret(ret),
			.jmp(jmp),
			.retAddr(retAddr),
			.target(target)
		);

		always_ff @(posedge clk or negedge rstN) begin
			if (!rstN) begin
				simtQ[s] <= '0;
				redirMaskQ[s] <= '0;
			end else begin
				simtQ[s] <= '{dotS: dotS, call: call, ret: ret, jmp: jmp, beq: entryD.beq,
					blt: entryD.blt, retAddr: retAddr, warpMask: slot[s].warpMask};
				redirMaskQ[s] <= (call || jmp) ? slot[s].warpMask : '0;
			end
		end

		always_ff @(posedge clk) begin
			entryQ[s] <= entryD;
			targetQ[s] <= target;
		end

		assign redirOut[s] = '{warpMask: redirMaskQ[s], target: targetQ[s]};

		assert property (@(posedge clk) disable iff (!rstN) $onehot0(slot[s].warpMask))
			else $error("Fetch slot %0d mask is not one-hot", s);
	end

	assign ibWrite0 = entryQ[0];
	assign ibWrite1 = entryQ[1];
	assign ibMask0 = simtQ[0].warpMask;
	assign ibMask1 = simtQ[1].warpMask;
	assign simtCtrl0 = simtQ[0];
	assign simtCtrl1 = simtQ[1];
	assign redirect0 = redirOut[0];
	assign redirect1 = redirOut[1];

	// Both slots must never carry the same warp
	assert property (@(posedge clk) disable iff (!rstN)
		(fetchSlot0.warpMask & fetchSlot1.warpMask) == '0)
		else $error("Fetch slots overlap");

endmodule

//--- gpuFrontEnd.sv
`timescale 1ns/1ns
`include "gpu_defines.svh"

module gpuFrontEnd (
	input logic clk,
	input logic rstN,
	input pipePkg::fetchSlotS fetchSlot0,
	input pipePkg::fetchSlotS fetchSlot1,
	input logic ibRead,
	input logic [`WARP_IDX_W-1:0] ibReadWarp,
	output logic [`XLEN-1:0] warpPc [`NUM_WARPS],
	output pipePkg::simtCtrlS simtCtrl0,
	output pipePkg::simtCtrlS simtCtrl1,
	output pipePkg::ibEntryS ibOut,
	output logic [`NUM_WARPS-1:0] ibValid
);

	pipePkg::ibEntryS ibWrite0;
	pipePkg::ibEntryS ibWrite1;
	logic [`NUM_WARPS-1:0] ibMask0;
	logic [`NUM_WARPS-1:0] ibMask1;
	pipePkg::pcRedirectS redirect0;
	pipePkg::pcRedirectS redirect1;

	decodeStage uDecode (
		.clk(clk),
		.rstN(rstN),
		.fetchSlot0(fetchSlot0),
		.fetchSlot1(fetchSlot1),
		.ibWrite0(ibWrite0),
		.ibWrite1(ibWrite1),
		.ibMask0(ibMask0),
		.ibMask1(ibMask1),
		.simtCtrl0(simtCtrl0),
		.simtCtrl1(simtCtrl1),
		.redirect0(redirect0),
		.redirect1(redirect1)
	);

	warpPcTable uPcTable (
		.clk(clk),
		.rstN(rstN),
		.redirect0(redirect0),
		.redirect1(redirect1),
		.warpPc(warpPc)
	);

	instrBuffer uIbuf (
		.clk(clk),
		.rstN(rstN),
		.ibWrite0(ibWrite0),
		.ibWrite1(ibWrite1),
		.ibMask0(ibMask0),
		.ibMask1(ibMask1),
		.ibRead(ibRead),
		.ibReadWarp(ibReadWarp),
		.ibOut(ibOut),
		.ibValid(ibValid)
	);

endmodule

//--- gpu_defines.svh
`ifndef GPU_DEFINES_SVH
`define GPU_DEFINES_SVH

`define NUM_WARPS 8 // Warps per core
`define WARP_IDX_W 3
`define RESET_PC 32'h0000_0000

`define XLEN 32 // PC and instruction word
`define REG_W 5 // Register index
`define IMM_W 16

`endif

//--- instrBuffer.sv
`timescale 1ns/1ns
`include "gpu_defines.svh"

module instrBuffer (
	input logic clk,
	input logic rstN,
	input pipePkg::ibEntryS ibWrite0,
	input pipePkg::ibEntryS ibWrite1,
	input logic [`NUM_WARPS-1:0] ibMask0,
	input logic [`NUM_WARPS-1:0] ibMask1,
	input logic ibRead,
	input logic [`WARP_IDX_W-1:0] ibReadWarp,
	output pipePkg::ibEntryS ibOut,
	output logic [`NUM_WARPS-1:0] ibValid
);

	pipePkg::ibEntryS entryQ [`NUM_WARPS];
	logic [`NUM_WARPS-1:0] validQ;
	logic [`NUM_WARPS-1:0] writeSet;
	logic [`NUM_WARPS-1:0] readClr;

	assign writeSet = ibMask0 | ibMask1;

	always_comb begin
		readClr = '0;
		if (ibRead) begin
			readClr[ibReadWarp] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validQ <= '0;
		end else begin
			validQ <= (validQ & ~readClr) | writeSet; // Write beats read-clear
		end
	end

	for (genvar w = 0; w < `NUM_WARPS; w++) begin : gEntry
		always_ff @(posedge clk) begin
			if (ibMask0[w]) begin
				entryQ[w] <= ibWrite0;
			end else if (ibMask1[w]) begin
				entryQ[w] <= ibWrite1;
			end
		end
	end

	assign ibOut = entryQ[ibReadWarp];
	assign ibValid = validQ;

	// No back-pressure, so a full entry that is not drained gets lost
	assert property (@(posedge clk) disable iff (!rstN)
		(writeSet & validQ & ~readClr) == '0)
		else $error("Instruction buffer entry overwritten");

	assert property (@(posedge clk) disable iff (!rstN) ibRead |-> validQ[ibReadWarp])
		else $error("Read of empty instruction buffer entry");

endmodule

//--- instrDecoder.sv
`timescale 1ns/1ns
`include "gpu_defines.svh"

module instrDecoder (
	input isaPkg::instrWordU instr,
	input logic [`XLEN-1:0] pcPlus4,
	output pipePkg::ibEntryS entry,
	output logic dotS,
	output logic call,
	output logic ret,
	output logic jmp,
	output logic [`XLEN-1:0] retAddr,
	output logic [`XLEN-1:0] target
);

	logic [5:0] baseOp;
	logic isInt;
	logic isNoop;
	logic isBeq;
	logic isBlt;
	logic isAddi;
	logic isAndi;
	logic isOri;
	logic isXori;
	logic isExit;
	logic isLd;
	logic isLds;
	logic isSw;
	logic isSws;
	logic immValid;
	logic memRead;
	logic memWrite;
	isaPkg::aluOpE aluOp;

	assign baseOp = instr.r.opcode & 6'b101111; // Drop the .S bit

	assign isInt = (baseOp == isaPkg::opInt);
	assign isNoop = (baseOp == isaPkg::opNoop);
	assign isBeq = (baseOp == isaPkg::opBeq);
	assign isBlt = (baseOp == isaPkg::opBlt);
	assign isAddi = (baseOp == isaPkg::opAddi);
	assign isAndi = (baseOp == isaPkg::opAndi);
	assign isOri = (baseOp == isaPkg::opOri);
	assign isXori = (baseOp == isaPkg::opXori);
	assign isExit = (baseOp == isaPkg::opExit);
	assign isLd = (baseOp == isaPkg::opLd);
	assign isLds = (baseOp == isaPkg::opLds);
	assign isSw = (baseOp == isaPkg::opSw);
	assign isSws = (baseOp == isaPkg::opSws);

	assign immValid = isAddi || isAndi || isOri || isXori;
	assign memRead = isLd || isLds;
	assign memWrite = isSw || isSws;

	// SIMT stack and PC redirect
	assign dotS = instr.r.opcode[4];
	assign call = (baseOp == isaPkg::opCall);
	assign ret = (baseOp == isaPkg::opRet);
	assign jmp = (baseOp == isaPkg::opJ);
	assign retAddr = pcPlus4 + 32'd4;
	assign target = {4'b0000, instr.j.target26, 2'b00};

	always_comb begin
		aluOp = isaPkg::aluNone;
		if (immValid) begin
			case (baseOp)
				isaPkg::opAddi: aluOp = isaPkg::aluAdd;
				isaPkg::opAndi: aluOp = isaPkg::aluAnd;
				isaPkg::opOri: aluOp = isaPkg::aluOr;
				isaPkg::opXori: aluOp = isaPkg::aluXor;
				default: aluOp = isaPkg::aluNone;
			endcase
		end else if (isInt) begin
			case (instr.r.funct)
				isaPkg::fnAdd: aluOp = isaPkg::aluAdd;
				isaPkg::fnSub: aluOp = isaPkg::aluSub;
				isaPkg::fnMul: aluOp = isaPkg::aluMul;
				isaPkg::fnAnd: aluOp = isaPkg::aluAnd;
				isaPkg::fnOr: aluOp = isaPkg::aluOr;
				isaPkg::fnXor: aluOp = isaPkg::aluXor;
				isaPkg::fnShr: aluOp = isaPkg::aluShr;
				isaPkg::fnShl: aluOp = isaPkg::aluShl;
				default: aluOp = isaPkg::aluNone; // Unknown funct
			endcase
		end
	end

	always_comb begin
		entry.instr = instr;
		entry.src1 = instr.r.rs;
		entry.src2 = instr.r.rt;
		entry.dst = (memRead || immValid) ? instr.i.rt : instr.r.rd; // Loads and I-type write rt
		entry.imm16 = instr.i.imm16;
		entry.aluOp = aluOp;
		entry.src1Valid = isInt || immValid || memRead || memWrite || isBeq || isBlt;
		entry.src2Valid = isInt || memWrite || isBeq || isBlt;
		entry.immValid = immValid;
		entry.regWrite = isInt || immValid || memRead;
		entry.memRead = memRead;
		entry.memWrite = memWrite;
		entry.sharedMem = isLds || isSws;
		entry.noop = isNoop;
		entry.exitWarp = isExit;
		entry.beq = isBeq;
		entry.blt = isBlt;
	end

endmodule

//--- isaPkg.sv
package isaPkg;

	// The .S twin of each opcode differs only in bit 4
	typedef enum logic [5:0] {
		opInt = 6'b000000, opIntS = 6'b010000,
		opNoop = 6'b000001, opNoopS = 6'b010001,
		opJ = 6'b000010, opJS = 6'b010010,
		opCall = 6'b000011, opCallS = 6'b010011,
		opBeq = 6'b000100, opBeqS = 6'b010100,
		opRet = 6'b000110, opRetS = 6'b010110,
		opBlt = 6'b000111, opBltS = 6'b010111,
		opAddi = 6'b001000, opAddiS = 6'b011000,
		opAndi = 6'b001100, opAndiS = 6'b011100,
		opOri = 6'b001101, opOriS = 6'b011101,
		opXori = 6'b001110, opXoriS = 6'b011110,
		opExit = 6'b100001, opExitS = 6'b110001,
		opLd = 6'b100011, opLdS = 6'b110011,
		opLds = 6'b100111, opLdsS = 6'b110111,
		opSw = 6'b101011, opSwS = 6'b111011,
		opSws = 6'b101111, opSwsS = 6'b111111
	} opcodeE;

	typedef enum logic [5:0] {
		fnAdd = 6'b100000,
		fnSub = 6'b100010,
		fnMul = 6'b011000,
		fnAnd = 6'b100100,
		fnOr = 6'b100101,
		fnXor = 6'b100110,
		fnShr = 6'b000010,
		fnShl = 6'b000000
	} functE;

	typedef enum logic [3:0] {
		aluAdd = 4'h0,
		aluSub = 4'h1,
		aluMul = 4'h2,
		aluAnd = 4'h3,
		aluOr = 4'h4,
		aluXor = 4'h5,
		aluShr = 4'h6,
		aluShl = 4'h7,
		aluNone = 4'hf // Not an ALU operation
	} aluOpE;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rViewS;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm16;
	} iViewS;

	typedef struct packed {
		logic [5:0] opcode;
		logic [25:0] target26;
	} jViewS;

	typedef union packed {
		rViewS r;
		iViewS i;
		jViewS j;
	} instrWordU;

endpackage

//--- pipePkg.sv
`include "gpu_defines.svh"

package pipePkg;

	typedef struct packed {
		isaPkg::instrWordU instr;
		logic [`XLEN-1:0] pcPlus4;
		logic [`NUM_WARPS-1:0] warpMask; // One-hot, zero for an empty slot
	} fetchSlotS;

	typedef struct packed {
		isaPkg::instrWordU instr;
		logic [`REG_W-1:0] src1;
		logic [`REG_W-1:0] src2;
		logic [`REG_W-1:0] dst;
		logic [`IMM_W-1:0] imm16;
		isaPkg::aluOpE aluOp;
		logic src1Valid;
		logic src2Valid;
		logic immValid;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic sharedMem; // Shared memory, else global
		logic noop;
		logic exitWarp;
		logic beq;
		logic blt;
	} ibEntryS;

	typedef struct packed {
		logic dotS;
		logic call;
		logic ret;
		logic jmp;
		logic beq;
		logic blt;
		logic [`XLEN-1:0] retAddr;
		logic [`NUM_WARPS-1:0] warpMask;
	} simtCtrlS;

	typedef struct packed {
		logic [`NUM_WARPS-1:0] warpMask; // Warps that take the target
		logic [`XLEN-1:0] target;
	} pcRedirectS;

endpackage

//--- tbGpuFrontEnd.sv
`timescale 1ns/1ns
`include "gpu_defines.svh"

module tbGpuFrontEnd;

	logic clk = 1'b0;
	logic rstN;
	pipePkg::fetchSlotS fetchSlot0;
	pipePkg::fetchSlotS fetchSlot1;
	logic ibRead;
	logic [`WARP_IDX_W-1:0] ibReadWarp;
	logic [`XLEN-1:0] warpPc [`NUM_WARPS];
	pipePkg::simtCtrlS simtCtrl0;
	pipePkg::simtCtrlS simtCtrl1;
	pipePkg::ibEntryS ibOut;
	logic [`NUM_WARPS-1:0] ibValid;

	integer seed = 84;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	logic timedOut = 1'b0;
	logic [`XLEN-1:0] pcModel [`NUM_WARPS];

	gpuFrontEnd UUT (.*);

	always #50 clk = ~clk;

	task automatic checkEntry(pipePkg::ibEntryS got, pipePkg::ibEntryS exp, string msg);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	task automatic checkSimt(pipePkg::simtCtrlS got, pipePkg::simtCtrlS exp, string msg);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	task automatic checkPc(logic [`XLEN-1:0] got, logic [`XLEN-1:0] exp, string msg);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	task automatic checkValid(logic [`NUM_WARPS-1:0] got, logic [`NUM_WARPS-1:0] exp, string msg);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, msg, got, exp);
			errors++;
		end
	endtask

	function automatic isaPkg::instrWordU encR(logic [5:0] op, logic [5:0] funct);
		isaPkg::instrWordU w;
		w.r.opcode = op;
		w.r.rs = $random(seed);
		w.r.rt = $random(seed);
		w.r.rd = $random(seed);
		w.r.shamt = $random(seed);
		w.r.funct = funct;
		return w;
	endfunction

	function automatic isaPkg::instrWordU encI(logic [5:0] op);
		isaPkg::instrWordU w;
		w.i.opcode = op;
		w.i.rs = $random(seed);
		w.i.rt = $random(seed);
		w.i.imm16 = $random(seed);
		return w;
	endfunction

	function automatic isaPkg::instrWordU encJ(logic [5:0] op);
		isaPkg::instrWordU w;
		w.j.opcode = op;
		w.j.target26 = $random(seed);
		return w;
	endfunction

	// Plain field copy, every flag clear, rd as destination
	function automatic pipePkg::ibEntryS entryFor(isaPkg::instrWordU w);
		pipePkg::ibEntryS e;
		e = '0;
		e.instr = w;
		e.src1 = w.r.rs;
		e.src2 = w.r.rt;
		e.dst = w.r.rd;
		e.imm16 = w.i.imm16;
		e.aluOp = isaPkg::aluNone;
		return e;
	endfunction

	function automatic pipePkg::simtCtrlS flagsFor(bit call, bit ret, bit jmp, bit beq, bit blt);
		pipePkg::simtCtrlS s;
		s = '0;
		s.call = call;
		s.ret = ret;
		s.jmp = jmp;
		s.beq = beq;
		s.blt = blt;
		return s;
	endfunction

	function automatic pipePkg::simtCtrlS simtFor(pipePkg::fetchSlotS f, pipePkg::simtCtrlS flags);
		pipePkg::simtCtrlS s;
		s = flags;
		s.dotS = f.instr.r.opcode[4];
		s.retAddr = f.pcPlus4 + 32'd4;
		s.warpMask = f.warpMask;
		return s;
	endfunction

	function automatic pipePkg::fetchSlotS makeSlot(pipePkg::ibEntryS e, int warp);
		pipePkg::fetchSlotS f;
		f.instr = e.instr;
		f.pcPlus4 = $random(seed) & 32'hffff_fffc;
		f.warpMask = 8'b1 << warp;
		return f;
	endfunction

	// Present both slots for one clock edge
	task automatic driveFetch(pipePkg::fetchSlotS f0, pipePkg::fetchSlotS f1);
		fetchSlot0 = f0;
		fetchSlot1 = f1;
		@(negedge clk);
		fetchSlot0.warpMask = '0;
		fetchSlot1.warpMask = '0;
	endtask

	task automatic waitValid(logic [`NUM_WARPS-1:0] mask);
		int n;
		n = 0;
		while ((ibValid & mask) != mask && n < 10) begin
			@(negedge clk);
			n++;
		end
		if ((ibValid & mask) != mask) begin
			$display("Timeout: buffer entries %b never became valid", mask);
			timedOut = 1'b1;
			forever @(negedge clk);
		end
	endtask

	task automatic readEntry(int warp, pipePkg::ibEntryS exp);
		ibReadWarp = warp;
		ibRead = 1'b1;
		#1;
		checkEntry(ibOut, exp, $sformatf("entry of warp %0d", warp));
		@(negedge clk);
		ibRead = 1'b0;
		checkValid(ibValid & (8'b1 << warp), '0, $sformatf("valid of warp %0d after read", warp));
	endtask

	task automatic checkAllPcs();
		for (int w = 0; w < `NUM_WARPS; w++) begin
			checkPc(warpPc[w], pcModel[w], $sformatf("PC of warp %0d", w));
		end
	endtask

	task automatic issueOne(bit useSlot1, int warp, pipePkg::ibEntryS e, pipePkg::simtCtrlS flags);
		pipePkg::fetchSlotS f;
		f = makeSlot(e, warp);
		if (useSlot1) begin
			driveFetch('0, f);
			checkSimt(simtCtrl1, simtFor(f, flags), "slot 1 SIMT control");
			checkValid(simtCtrl0.warpMask, '0, "idle slot 0 mask");
		end else begin
			driveFetch(f, '0);
			checkSimt(simtCtrl0, simtFor(f, flags), "slot 0 SIMT control");
			checkValid(simtCtrl1.warpMask, '0, "idle slot 1 mask");
		end
		waitValid(f.warpMask);
		if (flags.jmp || flags.call) begin
			pcModel[warp] = {4'b0000, e.instr.j.target26, 2'b00};
		end
		checkAllPcs();
		readEntry(warp, e);
	endtask

	task automatic issuePair(pipePkg::ibEntryS e0, int w0, pipePkg::ibEntryS e1, int w1);
		pipePkg::fetchSlotS f0;
		pipePkg::fetchSlotS f1;
		f0 = makeSlot(e0, w0);
		f1 = makeSlot(e1, w1);
		driveFetch(f0, f1);
		checkSimt(simtCtrl0, simtFor(f0, '0), "pair slot 0 SIMT control");
		checkSimt(simtCtrl1, simtFor(f1, '0), "pair slot 1 SIMT control");
		waitValid(f0.warpMask | f1.warpMask);
		readEntry(w0, e0);
		checkValid(ibValid, f1.warpMask, "valid after first read");
		readEntry(w1, e1);
	endtask

	function automatic pipePkg::ibEntryS aluEntry(logic [5:0] funct, isaPkg::aluOpE op);
		pipePkg::ibEntryS e;
		e = entryFor(encR(isaPkg::opInt, funct));
		e.src1Valid = 1'b1;
		e.src2Valid = 1'b1;
		e.regWrite = 1'b1;
		e.aluOp = op;
		return e;
	endfunction

	task automatic endTest(string name, int start);
		tests++;
		$display("Test %s finished with %0d errors", name, errors - start);
	endtask

	task automatic testReset();
		int start;
		start = errors;
		checkValid(ibValid, '0, "ibValid after reset");
		checkValid(simtCtrl0.warpMask, '0, "slot 0 mask after reset");
		checkValid(simtCtrl1.warpMask, '0, "slot 1 mask after reset");
		checkAllPcs();
		endTest("reset", start);
	endtask

	task automatic testRType();
		isaPkg::functE fns [8];
		isaPkg::aluOpE ops [8];
		pipePkg::ibEntryS e;
		int start;
		start = errors;
		fns = '{isaPkg::fnAdd, isaPkg::fnSub, isaPkg::fnMul, isaPkg::fnAnd, isaPkg::fnOr,
			isaPkg::fnXor, isaPkg::fnShr, isaPkg::fnShl};
		ops = '{isaPkg::aluAdd, isaPkg::aluSub, isaPkg::aluMul, isaPkg::aluAnd, isaPkg::aluOr,
			isaPkg::aluXor, isaPkg::aluShr, isaPkg::aluShl};
		for (int k = 0; k < 16; k++) begin
			e = aluEntry(fns[k / 2], ops[k / 2]);
			if (k % 2) begin
				e.instr.r.opcode = isaPkg::opIntS; // .S twin
			end
			issueOne(k % 2, k % 8, e, '0);
		end
		endTest("R-type ALU", start);
	endtask

	task automatic testITypeMem();
		isaPkg::opcodeE opsI [4];
		isaPkg::aluOpE alus [4];
		pipePkg::ibEntryS e;
		int start;
		start = errors;
		opsI = '{isaPkg::opAddi, isaPkg::opAndiS, isaPkg::opOri, isaPkg::opXoriS};
		alus = '{isaPkg::aluAdd, isaPkg::aluAnd, isaPkg::aluOr, isaPkg::aluXor};
		for (int k = 0; k < 4; k++) begin
			e = entryFor(encI(opsI[k]));
			e.dst = e.instr.i.rt;
			e.src1Valid = 1'b1;
			e.immValid = 1'b1;
			e.regWrite = 1'b1;
			e.aluOp = alus[k];
			issueOne(k % 2, k + 2, e, '0);
		end
		for (int k = 0; k < 2; k++) begin
			e = entryFor(encI(k ? isaPkg::opLdsS : isaPkg::opLd));
			e.dst = e.instr.i.rt;
			e.src1Valid = 1'b1;
			e.regWrite = 1'b1;
			e.memRead = 1'b1;
			e.sharedMem = k;
			issueOne(0, 6, e, '0);
			e = entryFor(encI(k ? isaPkg::opSws : isaPkg::opSwS));
			e.src1Valid = 1'b1;
			e.src2Valid = 1'b1;
			e.memWrite = 1'b1;
			e.sharedMem = k;
			issueOne(1, 7, e, '0);
		end
		issueOne(0, 1, aluEntry(6'b111111, isaPkg::aluNone), '0); // Unknown funct
		endTest("I-type and memory", start);
	endtask

	task automatic testControl();
		pipePkg::ibEntryS e;
		int start;
		start = errors;
		issueOne(0, 3, entryFor(encJ(isaPkg::opJ)), flagsFor(0, 0, 1, 0, 0));
		issueOne(1, 5, entryFor(encJ(isaPkg::opCallS)), flagsFor(1, 0, 0, 0, 0));
		issueOne(0, 2, entryFor(encJ(isaPkg::opRet)), flagsFor(0, 1, 0, 0, 0));
		e = entryFor(encI(isaPkg::opBeq));
		e.src1Valid = 1'b1;
		e.src2Valid = 1'b1;
		e.beq = 1'b1;
		issueOne(1, 4, e, flagsFor(0, 0, 0, 1, 0));
		e = entryFor(encI(isaPkg::opBltS));
		e.src1Valid = 1'b1;
		e.src2Valid = 1'b1;
		e.blt = 1'b1;
		issueOne(0, 6, e, flagsFor(0, 0, 0, 0, 1));
		e = entryFor(encJ(isaPkg::opExit));
		e.exitWarp = 1'b1;
		issueOne(1, 0, e, '0);
		e = entryFor(encJ(isaPkg::opNoop));
		e.noop = 1'b1;
		issueOne(0, 7, e, '0);
		e = entryFor(encJ(isaPkg::opNoopS));
		e.noop = 1'b1;
		issuePair(aluEntry(isaPkg::fnAdd, isaPkg::aluAdd), 0, e, 1); // Slot 1 no-op
		endTest("control flow", start);
	endtask

	task automatic testDualIssue();
		pipePkg::ibEntryS e0;
		pipePkg::ibEntryS e1;
		int w0;
		int w1;
		int start;
		start = errors;
		for (int k = 0; k < 4; k++) begin
			w0 = {$random(seed)} % `NUM_WARPS;
			w1 = (w0 + 1 + {$random(seed)} % (`NUM_WARPS - 1)) % `NUM_WARPS;
			issuePair(aluEntry(isaPkg::fnXor, isaPkg::aluXor), w0,
				aluEntry(isaPkg::fnMul, isaPkg::aluMul), w1);
		end
		// Write and read-clear of the same warp at one edge
		e0 = aluEntry(isaPkg::fnSub, isaPkg::aluSub);
		e1 = aluEntry(isaPkg::fnOr, isaPkg::aluOr);
		driveFetch(makeSlot(e0, w0), '0);
		waitValid(8'b1 << w0);
		driveFetch(makeSlot(e1, w0), '0);
		ibReadWarp = w0;
		ibRead = 1'b1;
		#1;
		checkEntry(ibOut, e0, "old entry before overlap");
		@(negedge clk);
		ibRead = 1'b0;
		checkValid(ibValid, 8'b1 << w0, "valid kept by overlapping write");
		readEntry(w0, e1);
		endTest("dual issue and read-clear", start);
	endtask

	initial begin
		wait (timedOut);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		rstN = 1'b0;
		fetchSlot0 = '0;
		fetchSlot1 = '0;
		ibRead = 1'b0;
		ibReadWarp = '0;
		for (int w = 0; w < `NUM_WARPS; w++) begin
			pcModel[w] = `RESET_PC;
		end
		repeat (3) @(negedge clk);
		rstN = 1'b1;
		testReset();
		testRType();
		testITypeMem();
		testControl();
		testDualIssue();
		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+.
isaPkg.sv
pipePkg.sv
instrDecoder.sv
decodeStage.sv
warpPcTable.sv
instrBuffer.sv
gpuFrontEnd.sv
tbGpuFrontEnd.sv

//--- warpPcTable.sv
`timescale 1ns/1ns
`include "gpu_defines.svh"

module warpPcTable (
	input logic clk,
	input logic rstN,
	input pipePkg::pcRedirectS redirect0,
	input pipePkg::pcRedirectS redirect1,
	output logic [`XLEN-1:0] warpPc [`NUM_WARPS]
);

	for (genvar w = 0; w < `NUM_WARPS; w++) begin : gWarp
		always_ff @(posedge clk or negedge rstN) begin
			if (!rstN) begin
				warpPc[w] <= `RESET_PC;
			end else if (redirect0.warpMask[w]) begin
				warpPc[w] <= redirect0.target; // Slot 0 jump or call
			end else if (redirect1.warpMask[w]) begin
				warpPc[w] <= redirect1.target;
			end
		end
	end

	// One warp is never redirected by both slots at once
	assert property (@(posedge clk) disable iff (!rstN)
		(redirect0.warpMask & redirect1.warpMask) == '0)
		else $error("Redirect masks overlap");

endmodule
